//--- common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;                     // Integer register width

    // Major opcodes, RV32I base encoding
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Nine conditions, so one bit more than funct3
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_LINK
    } wb_sel_e;

    localparam logic [6:0] FUNCT7_NORM = 7'b0000000;  // ADD, SRL, shifts
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // SUB, SRA

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;          // Branch conditions
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- common/ex_issue_if.sv
`timescale 1ns/1ps

interface ex_issue_if
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) ();

    logic            valid;      // Issue strobe, no backpressure
    alu_op_e         alu_op;
    br_op_e          br_op;
    wb_sel_e         wb_sel;     // Writeback source, follows the op down
    logic            illegal;
    logic [XLEN-1:0] op_a;       // rs1 or pc
    logic [XLEN-1:0] op_b;       // rs2 or imm
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imm;

    modport issuer (
        output valid, alu_op, br_op, wb_sel, illegal, op_a, op_b, pc, imm
    );

    modport unit (
        input valid, alu_op, br_op, wb_sel, illegal, op_a, op_b, pc, imm
    );

endinterface

//--- src/op_decode.sv
`timescale 1ns/1ps

module op_decode
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    input  logic            in_valid,
    ex_issue_if.issuer      issue
);

    opcode_e         opc;
    alu_op_e         arith_op;     // funct3/funct7 decode for OP and OP-IMM
    logic            arith_bad;
    br_op_e          cond_op;      // funct3 decode for BRANCH
    logic            cond_bad;
    alu_op_e         alu_op;
    br_op_e          br_op;
    wb_sel_e         wb_sel;
    logic            illegal;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    assign opc = opcode_e'(opcode);  // Unknown codes fall to default

    always_comb begin
        arith_op  = ALU_ADD;
        arith_bad = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                if (opc == OPC_OP && funct7 == FUNCT7_ALT) begin
                    arith_op = ALU_SUB;
                end else if (opc == OPC_OP && funct7 != FUNCT7_NORM) begin
                    arith_bad = 1'b1;                   // ADDI has no funct7
                end
            end
            F3_SLL: begin
                arith_op  = ALU_SLL;
                arith_bad = (funct7 != FUNCT7_NORM);
            end
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SRL_SRA: begin
                arith_op  = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                arith_bad = (funct7 != FUNCT7_NORM) && (funct7 != FUNCT7_ALT);
            end
            F3_OR:   arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        cond_bad = 1'b0;
        case (funct3)
            F3_BEQ:  cond_op = BR_BEQ;
            F3_BNE:  cond_op = BR_BNE;
            F3_BLT:  cond_op = BR_BLT;
            F3_BGE:  cond_op = BR_BGE;
            F3_BLTU: cond_op = BR_BLTU;
            F3_BGEU: cond_op = BR_BGEU;
            default: begin                              // 010 and 011 undefined
                cond_op  = BR_NONE;
                cond_bad = 1'b1;
            end
        endcase
    end

    always_comb begin
        op_a    = rs1_data;
        op_b    = rs2_data;
        alu_op  = ALU_ADD;
        br_op   = BR_NONE;
        wb_sel  = WB_NONE;
        illegal = 1'b0;
        case (opc)
            OPC_OP: begin
                alu_op  = arith_op;
                wb_sel  = WB_ALU;
                illegal = arith_bad;
            end
            OPC_OP_IMM: begin
                op_b    = imm;
                alu_op  = arith_op;
                wb_sel  = WB_ALU;
                illegal = arith_bad;
            end
            OPC_LUI: begin
                op_b   = imm;
                alu_op = ALU_PASS_B;
                wb_sel = WB_ALU;
            end
            OPC_AUIPC: begin
                op_a   = pc;                            // pc + imm on the ALU adder
                op_b   = imm;
                wb_sel = WB_ALU;
            end
            OPC_JAL: begin
                op_a   = pc;
                op_b   = imm;
                br_op  = BR_JAL;
                wb_sel = WB_LINK;
            end
            OPC_JALR: begin
                op_b   = imm;                           // rs1 + imm
                br_op  = BR_JALR;
                wb_sel = WB_LINK;
            end
            OPC_BRANCH: begin
                br_op   = cond_op;                      // rs1 vs rs2
                illegal = cond_bad;
            end
            default: illegal = 1'b1;                    // Unknown opcode
        endcase
        if (illegal) begin                              // Neutral op, result dropped
            alu_op = ALU_ADD;
            br_op  = BR_NONE;
            wb_sel = WB_NONE;
        end
    end

    assign issue.valid   = in_valid;
    assign issue.alu_op  = alu_op;
    assign issue.br_op   = br_op;
    assign issue.wb_sel  = wb_sel;
    assign issue.illegal = illegal;
    assign issue.op_a    = op_a;
    assign issue.op_b    = op_b;
    assign issue.pc      = pc;
    assign issue.imm     = imm;

endmodule

//--- alu/alu.sv
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst,
    ex_issue_if.unit        issue,
    output logic            alu_valid,
    output logic [XLEN-1:0] alu_result,
    output wb_sel_e         alu_wb_sel,
    output logic            alu_illegal
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] lt_s;         // Compare results, zero extended
    logic [XLEN-1:0] lt_u;

    assign shamt = issue.op_b[4:0];  // Upper bits of op_b ignored for shifts
    assign lt_s  = {{(XLEN-1){1'b0}}, $signed(issue.op_a) < $signed(issue.op_b)};
    assign lt_u  = {{(XLEN-1){1'b0}}, issue.op_a < issue.op_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue.valid;
        end
    end

    // Payload only moves on an issued op
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            case (issue.alu_op)
                ALU_ADD:    alu_result <= issue.op_a + issue.op_b;
                ALU_SUB:    alu_result <= issue.op_a - issue.op_b;
                ALU_SLL:    alu_result <= issue.op_a << shamt;          // Zero fill
                ALU_SLT:    alu_result <= lt_s;
                ALU_SLTU:   alu_result <= lt_u;
                ALU_XOR:    alu_result <= issue.op_a ^ issue.op_b;
                ALU_SRL:    alu_result <= issue.op_a >> shamt;
                ALU_SRA:    alu_result <= $signed(issue.op_a) >>> shamt;  // Sign fill
                ALU_OR:     alu_result <= issue.op_a | issue.op_b;
                ALU_AND:    alu_result <= issue.op_a & issue.op_b;
                ALU_PASS_B: alu_result <= issue.op_b;                   // LUI
                default:    alu_result <= '0;
            endcase
            alu_wb_sel  <= issue.wb_sel;
            alu_illegal <= issue.illegal;
        end
    end

    // Decoder must never hand over an unassigned op code
    a_alu_op_known: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> issue.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
            ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B})
        else $error("alu: unknown alu_op %0d", issue.alu_op);

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst,
    ex_issue_if.unit        issue,
    output logic            br_valid,
    output logic            br_taken,
    output logic [XLEN-1:0] br_target,
    output logic [XLEN-1:0] br_link
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic [XLEN-1:0] base;         // pc, or rs1 for JALR
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] target;

    assign eq   = (issue.op_a == issue.op_b);
    assign lt_s = ($signed(issue.op_a) < $signed(issue.op_b));
    assign lt_u = (issue.op_a < issue.op_b);

    always_comb begin
        case (issue.br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_JAL,
            BR_JALR: taken = 1'b1;     // Jumps always redirect
            default: taken = 1'b0;
        endcase
    end

    assign base   = (issue.br_op == BR_JALR) ? issue.op_a : issue.pc;
    assign sum    = base + issue.imm;  // Own adder, ALU stays free
    assign target = (issue.br_op == BR_JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            br_valid <= 1'b0;
            br_taken <= 1'b0;
        end else begin
            br_valid <= issue.valid;
            br_taken <= issue.valid && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            br_target <= target;
            br_link   <= issue.pc + XLEN'(4);  // Return address
        end
    end

    a_taken_valid: assert property (@(posedge clk) disable iff (rst)
        br_taken |-> br_valid)
        else $error("branch_unit: br_taken without br_valid");

endmodule

//--- src/ex_commit.sv
`timescale 1ns/1ps

module ex_commit
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            alu_valid,
    input  logic [XLEN-1:0] alu_result,
    input  wb_sel_e         alu_wb_sel,
    input  logic            alu_illegal,
    input  logic            br_valid,
    input  logic            br_taken,
    input  logic [XLEN-1:0] br_target,
    input  logic [XLEN-1:0] br_link,
    output logic            out_valid,
    output logic [XLEN-1:0] out_result,
    output logic            out_illegal,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    logic            squash;       // Shadow slot behind a redirect
    logic            accept;
    logic            redirect;
    logic [XLEN-1:0] wb_value;

    assign accept   = alu_valid && !squash;
    assign redirect = accept && br_taken && !alu_illegal;

    always_comb begin
        case (alu_wb_sel)
            WB_ALU:  wb_value = alu_result;
            WB_LINK: wb_value = br_link;     // pc + 4 for jumps
            default: wb_value = '0;          // Branches write nothing
        endcase
        if (alu_illegal) begin
            wb_value = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid      <= 1'b0;
            out_illegal    <= 1'b0;
            redirect_valid <= 1'b0;
            squash         <= 1'b0;
        end else begin
            out_valid      <= accept;
            out_illegal    <= accept && alu_illegal;
            redirect_valid <= redirect;
            squash         <= redirect;  // Lasts one cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_result  <= wb_value;
            redirect_pc <= br_target;
        end
    end

    // Both units see the same issue strobe
    a_units_aligned: assert property (@(posedge clk) disable iff (rst)
        alu_valid == br_valid)
        else $error("ex_commit: alu_valid and br_valid differ");

    a_redirect_has_result: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> out_valid)
        else $error("ex_commit: redirect without out_valid");

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
    import rv_pkg::*;
#(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic            out_valid,
    output logic [XLEN-1:0] out_result,
    output logic            out_illegal,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    logic            alu_valid;
    logic [XLEN-1:0] alu_result;
    wb_sel_e         alu_wb_sel;
    logic            alu_illegal;
    logic            br_valid;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;

    ex_issue_if #(.XLEN(XLEN)) issue ();  // Decoder to both units

    op_decode #(.XLEN(XLEN)) i_op_decode (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (pc),
        .in_valid (in_valid),
        .issue    (issue)
    );

    alu #(.XLEN(XLEN)) i_alu (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .alu_valid   (alu_valid),
        .alu_result  (alu_result),
        .alu_wb_sel  (alu_wb_sel),
        .alu_illegal (alu_illegal)
    );

    branch_unit #(.XLEN(XLEN)) i_branch_unit (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_link   (br_link)
    );

    ex_commit #(.XLEN(XLEN)) i_ex_commit (
        .clk            (clk),
        .rst            (rst),
        .alu_valid      (alu_valid),
        .alu_result     (alu_result),
        .alu_wb_sel     (alu_wb_sel),
        .alu_illegal    (alu_illegal),
        .br_valid       (br_valid),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .br_link        (br_link),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_illegal    (out_illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

//--- verification/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage
    import rv_pkg::*;
();

    localparam int N_RAND      = 200;            // Random OP and OP-IMM issues
    localparam int N_DIRECTED  = 100;            // Upper bound on directed issues
    localparam int CYCLE_LIMIT = (N_RAND + N_DIRECTED) * 2 + 100;

    typedef struct packed {
        int          due;                        // Cycle in which out_valid shows it
        logic [31:0] result;
        logic        illegal;
        logic        redir;
        logic [31:0] rpc;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        out_valid;
    logic [31:0] out_result;
    logic        out_illegal;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    exp_t        exp_q[$];                       // Model results in issue order
    exp_t        exp_cur;                        // Expected output this cycle
    logic        exp_valid;
    logic        shadow;                         // Last issue was a taken transfer
    int          cycle = 0;
    integer      seed;

    ex_stage i_ex_stage (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .opcode         (opcode),
        .funct3         (funct3),
        .funct7         (funct7),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .imm            (imm),
        .pc             (pc),
        .out_valid      (out_valid),
        .out_result     (out_result),
        .out_illegal    (out_illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                  // 20 ns period
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: no clean finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    // Head of the queue becomes the expectation once its cycle arrives
    always @(negedge clk) begin
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            exp_cur   = exp_q.pop_front();
            exp_valid = 1'b1;
        end else begin
            exp_valid = 1'b0;
        end
    end

    task automatic report_error(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, got, expected);
        $display("Test FAILED");
        $fatal(1);
    endtask

    a_out_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid == exp_valid)
        else report_error("out_valid", 32'($sampled(out_valid)), 32'(exp_valid));

    a_result: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> out_result == exp_cur.result)
        else report_error("out_result", $sampled(out_result), exp_cur.result);

    a_illegal: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> out_illegal == exp_cur.illegal)
        else report_error("out_illegal", 32'($sampled(out_illegal)), 32'(exp_cur.illegal));

    a_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect_valid == (exp_valid && exp_cur.redir))
        else report_error("redirect_valid", 32'($sampled(redirect_valid)),
                          32'(exp_valid && exp_cur.redir));

    a_redirect_pc: assert property (@(posedge clk) disable iff (rst)
        (exp_valid && exp_cur.redir) |-> redirect_pc == exp_cur.rpc)
        else report_error("redirect_pc", $sampled(redirect_pc), exp_cur.rpc);

    // Reference model straight from the RV32I rules
    function automatic exp_t predict(input logic [6:0] opc, input logic [2:0] f3,
                                     input logic [6:0] f7, input logic [31:0] a,
                                     input logic [31:0] rs2, input logic [31:0] immv,
                                     input logic [31:0] pcv);
        exp_t        e;
        logic [31:0] b;
        logic        alt;
        logic        taken;
        e     = '0;
        b     = (opc == OPC_OP) ? rs2 : immv;    // Immediate form takes imm
        alt   = (f7 == FUNCT7_ALT);
        taken = 1'b0;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                case (f3)
                    F3_ADD_SUB: begin
                        e.illegal = (opc == OPC_OP) && !alt && (f7 != FUNCT7_NORM);
                        e.result  = (opc == OPC_OP && alt) ? a - b : a + b;
                    end
                    F3_SLL: begin
                        e.illegal = (f7 != FUNCT7_NORM);
                        e.result  = a << b[4:0];
                    end
                    F3_SLT:  e.result = {31'b0, $signed(a) < $signed(b)};
                    F3_SLTU: e.result = {31'b0, a < b};
                    F3_XOR:  e.result = a ^ b;
                    F3_SRL_SRA: begin
                        e.illegal = !alt && (f7 != FUNCT7_NORM);
                        if (alt) begin
                            e.result = $signed(a) >>> b[4:0];  // Sign fill
                        end else begin
                            e.result = a >> b[4:0];
                        end
                    end
                    F3_OR:   e.result = a | b;
                    default: e.result = a & b;
                endcase
            end
            OPC_LUI:   e.result = immv;
            OPC_AUIPC: e.result = pcv + immv;
            OPC_JAL: begin
                e.result = pcv + 32'd4;
                e.redir  = 1'b1;
                e.rpc    = pcv + immv;
            end
            OPC_JALR: begin
                e.result = pcv + 32'd4;
                e.redir  = 1'b1;
                e.rpc    = (a + immv) & 32'hffff_fffe;  // Bit 0 cleared
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == rs2);
                    F3_BNE:  taken = (a != rs2);
                    F3_BLT:  taken = $signed(a) < $signed(rs2);
                    F3_BGE:  taken = !($signed(a) < $signed(rs2));
                    F3_BLTU: taken = a < rs2;
                    F3_BGEU: taken = !(a < rs2);
                    default: e.illegal = 1'b1;
                endcase
                e.redir = taken;
                e.rpc   = pcv + immv;
            end
            default: e.illegal = 1'b1;           // Unknown opcode
        endcase
        if (e.illegal) begin
            e.result = '0;
            e.redir  = 1'b0;
        end
        return e;
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] rand_pc();
        return rand_word() & 32'hffff_fffc;      // Word aligned
    endfunction

    task automatic issue_op(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] immv, input logic [31:0] pcv);
        exp_t e;
        in_valid = 1'b1;
        opcode   = opc;
        funct3   = f3;
        funct7   = f7;
        rs1_data = a;
        rs2_data = b;
        imm      = immv;
        pc       = pcv;
        e        = predict(opc, f3, f7, a, b, immv, pcv);
        e.due    = cycle + 2;
        if (!shadow) begin
            exp_q.push_back(e);                  // Shadow slot gives no result
        end
        shadow = !shadow && e.redir;
        @(negedge clk);
    endtask

    task automatic idle();
        in_valid = 1'b0;
        opcode   = 7'(rand_word());              // Junk fields the DUT ignores
        rs1_data = rand_word();
        shadow   = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        int          i;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        seed      = 32'h9d25_f26c;
        rst       = 1'b1;
        in_valid  = 1'b0;
        opcode    = '0;
        funct3    = '0;
        funct7    = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        imm       = '0;
        pc        = '0;
        exp_valid = 1'b0;
        exp_cur   = '0;
        shadow    = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) idle();                       // Outputs must stay low here

        // Sign boundary compares and oversized shift amounts
        issue_op(OPC_OP, F3_SLT, FUNCT7_NORM, 32'h8000_0000, 32'h7fff_ffff, 0, rand_pc());
        issue_op(OPC_OP, F3_SLTU, FUNCT7_NORM, 32'h8000_0000, 32'h7fff_ffff, 0, rand_pc());
        issue_op(OPC_OP, F3_SLT, FUNCT7_NORM, 32'hffff_ffff, 32'h1, 0, rand_pc());
        issue_op(OPC_OP, F3_SLTU, FUNCT7_NORM, 32'hffff_ffff, 32'h1, 0, rand_pc());
        issue_op(OPC_OP, F3_SRL_SRA, FUNCT7_ALT, 32'h8000_00f0, 32'h0000_0124, 0, rand_pc());
        issue_op(OPC_OP, F3_SLL, FUNCT7_NORM, 32'h0000_0003, 32'hffff_ffe3, 0, rand_pc());

        for (i = 0; i < N_RAND; i++) begin      // Back to back on every cycle
            opc = ((rand_word() & 32'h1) != 0) ? OPC_OP : OPC_OP_IMM;
            f3  = 3'(rand_word());
            f7  = FUNCT7_NORM;
            if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && (rand_word() & 32'h1) != 0) begin
                f7 = FUNCT7_ALT;
            end
            issue_op(opc, f3, f7, rand_word(), rand_word(), rand_word(), rand_pc());
        end

        issue_op(OPC_LUI, 3'(rand_word()), 7'(rand_word()), rand_word(), rand_word(),
                 rand_word() & 32'hffff_f000, rand_pc());
        issue_op(OPC_LUI, 3'(rand_word()), 7'(rand_word()), 0, 0, 32'h8000_0000, rand_pc());
        issue_op(OPC_AUIPC, 3'(rand_word()), 7'(rand_word()), rand_word(), rand_word(),
                 rand_word() & 32'hffff_f000, rand_pc());
        issue_op(OPC_AUIPC, 0, 0, 0, 0, 32'hffff_f000, 32'h0000_0ffc);

        // Each condition taken and not taken with its shadow slot and successor
        for (i = 0; i < 18; i++) begin
            case (i / 3)
                0:       f3 = F3_BEQ;
                1:       f3 = F3_BNE;
                2:       f3 = F3_BLT;
                3:       f3 = F3_BGE;
                4:       f3 = F3_BLTU;
                default: f3 = F3_BGEU;
            endcase
            case (i % 3)
                0: begin
                    a = rand_word();
                    b = a;
                end
                1: begin
                    a = 32'h8000_0000;
                    b = 32'h1;
                end
                default: begin
                    a = 32'h1;
                    b = 32'h8000_0000;
                end
            endcase
            issue_op(OPC_BRANCH, f3, 7'(rand_word()), a, b, rand_word() & 32'h1ffe, rand_pc());
            issue_op(OPC_OP, F3_ADD_SUB, FUNCT7_NORM, rand_word(), rand_word(), 0, rand_pc());
            issue_op(OPC_OP, F3_ADD_SUB, FUNCT7_NORM, rand_word(), rand_word(), 0, rand_pc());
        end

        issue_op(OPC_JAL, 0, 0, rand_word(), rand_word(), rand_word() & 32'hfffe, rand_pc());
        issue_op(OPC_OP, F3_XOR, FUNCT7_NORM, rand_word(), rand_word(), 0, rand_pc());
        issue_op(OPC_OP, F3_OR, FUNCT7_NORM, rand_word(), rand_word(), 0, rand_pc());
        issue_op(OPC_JALR, 0, 0, rand_word(), rand_word(), rand_word() | 32'h1, rand_pc());
        issue_op(OPC_JAL, 0, 0, 0, 0, 32'h100, rand_pc());  // Squashed jump gives no redirect
        issue_op(OPC_OP, F3_AND, FUNCT7_NORM, rand_word(), rand_word(), 0, rand_pc());

        issue_op(OPC_OP, F3_ADD_SUB, 7'h01, rand_word(), rand_word(), 0, rand_pc());
        issue_op(OPC_OP, F3_SLL, FUNCT7_ALT, rand_word(), rand_word(), 0, rand_pc());
        issue_op(OPC_OP_IMM, F3_SRL_SRA, 7'h7f, rand_word(), rand_word(), 5, rand_pc());
        issue_op(7'h0b, 0, 0, rand_word(), rand_word(), rand_word(), rand_pc());
        issue_op(OPC_BRANCH, 3'b010, 0, 5, 5, 32'h40, rand_pc());

        while (exp_q.size() != 0) begin
            idle();
        end
        repeat (2) idle();
        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog.f
common/rv_pkg.sv
common/ex_issue_if.sv
src/op_decode.sv
alu/alu.sv
src/branch_unit.sv
src/ex_commit.sv
src/ex_stage.sv
verification/tb_ex_stage.sv

//--- Makefile
TOP := tb_ex_stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Test OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
